//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_color_proc
FILELIST  ?= project.f
PASS_MSG  := Regression passed
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/color_classifier.sv
// purely combinational, decides on the data cycle of each pixel
// only the two msbs of every channel take part in the decision
module color_classifier (
  input  color_pkg::pxl_t         pxl_i,
  input  color_pkg::filter_mode_e mode_i,
  output logic                    pass_o,
  output color_pkg::pxl_t         proc_pxl_o
);
  import color_pkg::*;

  chan_t red;
  chan_t grn;
  chan_t blu;
  // RRGGBB, each channel quantized to 2 bits
  logic [5:0] qidx;
  class_t cls;
  logic pass;

  // split the RGB444 word into channels
  assign red = pxl_i[11:8];
  assign grn = pxl_i[7:4];
  assign blu = pxl_i[3:0];

  assign qidx = {red[3:2], grn[3:2], blu[3:2]};
  assign cls = class_table[qidx];

  // mode picks which class flag lets the pixel through
  always_comb begin
    case (mode_i)
      filt_none:    pass = 1'b1;
      filt_red:     pass = |(cls & cls_red);
      filt_green:   pass = |(cls & cls_grn);
      filt_blue:    pass = |(cls & cls_blu);
      // red plus green channels
      filt_yellow:  pass = |(cls & cls_yel);
      filt_magenta: pass = |(cls & cls_mag);
      filt_cyan:    pass = |(cls & cls_cya);
      filt_white:   pass = |(cls & cls_whi);
      default:      pass = 1'b1;
    endcase
  end

  assign pass_o = pass;

  // rejected pixels are written as black
  assign proc_pxl_o = pass ? pxl_i : '0;

endmodule

//--- hw/color_pkg.sv
// RGB444 pixel format, filter modes and the quantized color class table
// class table is indexed by the two msbs of each channel as {r, g, b}
package color_pkg;

  // red in [11:8], green in [7:4], blue in [3:0]
  typedef logic [11:0] pxl_t;
  typedef logic [3:0] chan_t;

  // one bit per enabled channel, {red, green, blue}
  typedef enum logic [2:0] {
    filt_none    = 3'b000,
    filt_red     = 3'b100,
    filt_green   = 3'b010,
    filt_blue    = 3'b001,
    filt_yellow  = 3'b110,
    filt_magenta = 3'b101,
    filt_cyan    = 3'b011,
    filt_white   = 3'b111
  } filter_mode_e;

  // class flags, a pixel may belong to several classes or none
  typedef logic [6:0] class_t;

  localparam class_t cls_none = 7'b000_0000;
  localparam class_t cls_red = 7'b000_0001;
  localparam class_t cls_grn = 7'b000_0010;
  localparam class_t cls_blu = 7'b000_0100;
  localparam class_t cls_yel = 7'b000_1000;
  localparam class_t cls_cya = 7'b001_0000;
  localparam class_t cls_mag = 7'b010_0000;
  localparam class_t cls_whi = 7'b100_0000;

  // one line per {r, g} pair, the four entries are b = 0 to 3
  localparam class_t class_table [0:63] = '{
    // r = 0
    cls_none, cls_blu, cls_blu, cls_blu,
    cls_grn, cls_cya, cls_blu | cls_cya, cls_blu,
    cls_grn, cls_grn | cls_cya, cls_cya, cls_blu | cls_cya,
    cls_grn, cls_grn, cls_grn | cls_cya, cls_cya,
    // r = 1
    cls_red, cls_mag, cls_blu | cls_mag, cls_blu,
    cls_yel, cls_whi, cls_blu | cls_cya | cls_mag | cls_whi, cls_blu,
    cls_grn | cls_yel, cls_grn | cls_whi, cls_cya, cls_blu | cls_cya,
    cls_grn, cls_grn, cls_grn | cls_cya, cls_cya,
    // r = 2
    cls_red, cls_red | cls_mag, cls_mag, cls_blu | cls_mag,
    cls_red | cls_yel, cls_red | cls_whi, cls_mag, cls_blu | cls_mag,
    cls_yel, cls_yel, cls_whi, cls_blu | cls_whi,
    cls_grn | cls_yel, cls_grn | cls_yel, cls_grn | cls_whi, cls_cya | cls_whi,
    // r = 3
    cls_red, cls_red, cls_red | cls_mag, cls_mag,
    cls_red, cls_red, cls_red | cls_mag, cls_mag,
    cls_red | cls_yel, cls_red | cls_yel, cls_red | cls_whi, cls_mag | cls_whi,
    cls_yel, cls_yel, cls_yel | cls_whi, cls_whi
  };

endpackage

//--- hw/color_proc_top.sv
// color filter over a 160 x 120 RGB444 frame with an 8-bin column histogram
// both memories must take one access per cycle, read data one cycle late
module color_proc_top #(
  parameter int outframe_cols = 16,
  parameter int outframe_rows = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     proc_ctrl_i,
  input  logic                     new_frame_i,
  // original image memory
  input  color_pkg::pxl_t          orig_pxl_i,
  output img_geom_pkg::pxl_addr_t  orig_addr_o,
  // processed image memory
  output logic                     proc_we_o,
  output color_pkg::pxl_t          proc_pxl_o,
  output img_geom_pkg::pxl_addr_t  proc_addr_o,
  // frame results
  output logic                     new_frame_proc_o,
  output img_geom_pkg::pxl_count_t colorpxls_o,
  output img_geom_pkg::hist_bins_t hist_o,
  output color_pkg::filter_mode_e  filter_o
);
  import color_pkg::*;

  filter_mode_e mode;
  logic pass;

  // position info from scanner to accumulator
  scan_if scan_bus ();

  frame_scanner #(
    .outframe_cols (outframe_cols),
    .outframe_rows (outframe_rows)
  ) frame_scanner_inst (
    .clk         (clk),
    .rst         (rst),
    .new_frame_i (new_frame_i),
    .orig_addr_o (orig_addr_o),
    .proc_addr_o (proc_addr_o),
    .proc_we_o   (proc_we_o),
    .scan        (scan_bus.scanner)
  );

  filter_selector filter_selector_inst (
    .clk         (clk),
    .rst         (rst),
    .proc_ctrl_i (proc_ctrl_i),
    .mode_o      (mode)
  );

  // works on the returned pixel in its data cycle
  color_classifier color_classifier_inst (
    .pxl_i      (orig_pxl_i),
    .mode_i     (mode),
    .pass_o     (pass),
    .proc_pxl_o (proc_pxl_o)
  );

  hist_accumulator hist_accumulator_inst (
    .clk          (clk),
    .rst          (rst),
    .scan         (scan_bus.accum),
    .pass_i       (pass),
    .hist_o       (hist_o),
    .colorpxls_o  (colorpxls_o),
    .frame_done_o (new_frame_proc_o)
  );

  assign filter_o = mode;

endmodule

//--- hw/filter_selector.sv
// push button steps through the eight filter modes, one step per press
// no debounce here, a bouncing button may advance more than one mode
module filter_selector (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      proc_ctrl_i,
  output color_pkg::filter_mode_e   mode_o
);
  import color_pkg::*;

  logic btn_meta;
  logic btn_sync;
  logic btn_prev;
  logic btn_rise;
  filter_mode_e mode;

  // two flop synchronizer then one more stage for the edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      btn_meta <= 1'b0;
      btn_sync <= 1'b0;
      btn_prev <= 1'b0;
    end else begin
      btn_meta <= proc_ctrl_i;
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;
    end
  end

  assign btn_rise = btn_sync & ~btn_prev;

  // fixed order: none, single channels, channel pairs, then white
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mode <= filt_none;
    end else if (btn_rise) begin
      case (mode)
        filt_none:    mode <= filt_red;
        filt_red:     mode <= filt_green;
        filt_green:   mode <= filt_blue;
        filt_blue:    mode <= filt_yellow;
        filt_yellow:  mode <= filt_magenta;
        filt_magenta: mode <= filt_cyan;
        filt_cyan:    mode <= filt_white;
        default:      mode <= filt_none;
      endcase
    end
  end

  assign mode_o = mode;

endmodule

//--- hw/frame_scanner.sv
// walks the whole image once per new_frame_i, one address per cycle, no stall
// memory is assumed to return data exactly one cycle after the address
module frame_scanner #(
  parameter int outframe_cols = 16,
  parameter int outframe_rows = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    new_frame_i,
  output img_geom_pkg::pxl_addr_t orig_addr_o,
  output img_geom_pkg::pxl_addr_t proc_addr_o,
  output logic                    proc_we_o,
  scan_if.scanner                 scan
);
  import img_geom_pkg::*;

  // columns left after both margins, its msbs select the bin
  localparam int inner_cols = img_cols - 2 * outframe_cols;
  localparam int inner_col_w = $clog2(inner_cols);

  logic busy;
  pxl_addr_t addr;
  col_t col;
  row_t row;
  logic end_pxl;
  logic end_ln;

  // one cycle behind the address, aligned with the returned data
  logic valid_d;
  logic last_d;
  pxl_addr_t addr_d;
  col_t col_d;
  row_t row_d;
  col_t col_in;

  assign end_pxl = (addr == pxl_addr_t'(img_pxls - 1));
  assign end_ln = (col == col_t'(img_cols - 1));

  // address, column and row counters, all run only while busy
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
      addr <= '0;
      col <= '0;
      row <= '0;
      valid_d <= 1'b0;
      last_d <= 1'b0;
    end else begin
      valid_d <= busy;
      last_d <= busy & end_pxl;
      if (busy) begin
        if (end_pxl) begin
          busy <= 1'b0;
          addr <= '0;
          col <= '0;
          row <= '0;
        end else begin
          addr <= addr + 1'b1;
          col <= end_ln ? '0 : col + 1'b1;
          if (end_ln) begin
            row <= row + 1'b1;
          end
        end
      end else if (new_frame_i) begin
        // a request during a frame is simply not seen
        busy <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    addr_d <= addr;
    col_d <= col;
    row_d <= row;
  end

  assign orig_addr_o = addr;
  assign proc_addr_o = addr_d;
  assign proc_we_o = valid_d;

  assign scan.data_valid = valid_d;
  assign scan.frame_last = last_d;
  assign scan.inner = (col_d >= col_t'(outframe_cols)) &&
                      (col_d < col_t'(img_cols - outframe_cols)) &&
                      (row_d >= row_t'(outframe_rows)) &&
                      (row_d < row_t'(img_rows - outframe_rows));

  // outside the inner frame this wraps, the accumulator ignores it there
  assign col_in = col_d - col_t'(outframe_cols);
  assign scan.bin = col_in[inner_col_w-1 -: bin_w];

endmodule

//--- hw/hist_accumulator.sv
// counts passing inner-frame pixels per column bin and in total
// results are held from the frame end until the next frame ends
module hist_accumulator (
  input  logic                     clk,
  input  logic                     rst,
  scan_if.accum                    scan,
  input  logic                     pass_i,
  output img_geom_pkg::hist_bins_t hist_o,
  output img_geom_pkg::pxl_count_t colorpxls_o,
  output logic                     frame_done_o
);
  import img_geom_pkg::*;

  // running counts of the frame in progress
  hist_bins_t hist_cnt;
  pxl_count_t total_cnt;
  // counts with the current pixel already added
  hist_bins_t hist_nxt;
  pxl_count_t total_nxt;
  logic count_en;

  assign count_en = scan.data_valid & scan.inner & pass_i;

  always_comb begin
    hist_nxt = hist_cnt;
    total_nxt = total_cnt;
    if (count_en) begin
      hist_nxt[scan.bin] = hist_cnt[scan.bin] + 1'b1;
      total_nxt = total_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hist_cnt <= '0;
      total_cnt <= '0;
      hist_o <= '0;
      colorpxls_o <= '0;
      frame_done_o <= 1'b0;
    end else begin
      frame_done_o <= scan.frame_last;
      if (scan.frame_last) begin
        // last pixel goes straight into the outputs
        hist_o <= hist_nxt;
        colorpxls_o <= total_nxt;
        hist_cnt <= '0;
        total_cnt <= '0;
      end else begin
        hist_cnt <= hist_nxt;
        total_cnt <= total_nxt;
      end
    end
  end

endmodule

//--- hw/img_geom_pkg.sv
// frame geometry for a fixed 160 x 120 image with an 8-bin column histogram
// widths are derived here so counters cannot overflow at their maximum values
package img_geom_pkg;

  // full image, QQVGA
  localparam int img_cols = 160;
  localparam int img_rows = 120;
  localparam int img_pxls = img_cols * img_rows;

  // inner frame with the default margins (16 columns, 8 rows on each side)
  localparam int inframe_cols = 128;
  localparam int inframe_rows = 104;

  // histogram splits the inner columns into equal bins
  localparam int hist_bins = 8;

  localparam int pxl_addr_w = $clog2(img_pxls);
  localparam int col_w = $clog2(img_cols);
  localparam int row_w = $clog2(img_rows);
  localparam int bin_w = $clog2(hist_bins);
  // one bin holds at most 104 rows x 16 columns = 1664
  localparam int hist_val_w = $clog2(inframe_rows * (inframe_cols / hist_bins) + 1);
  // whole inner frame, at most 13312
  localparam int pxl_count_w = $clog2(inframe_cols * inframe_rows + 1);

  typedef logic [pxl_addr_w-1:0] pxl_addr_t;
  typedef logic [col_w-1:0] col_t;
  typedef logic [row_w-1:0] row_t;
  typedef logic [bin_w-1:0] bin_t;
  typedef logic [hist_val_w-1:0] hist_val_t;
  typedef logic [pxl_count_w-1:0] pxl_count_t;

  // index 0 is the leftmost bin
  typedef hist_val_t [hist_bins-1:0] hist_bins_t;

endpackage

//--- hw/scan_if.sv
// pixel position that travels with each memory data cycle
// every field is only meaningful while data_valid is high
interface scan_if;
  import img_geom_pkg::*;

  // memory data for one pixel is on the bus this cycle
  logic data_valid;
  // pixel lies inside the inner frame
  logic inner;
  // histogram bin of the pixel column
  bin_t bin;
  // data cycle of the last pixel in the frame
  logic frame_last;

  modport scanner (
    output data_valid, inner, bin, frame_last
  );

  modport accum (
    input data_valid, inner, bin, frame_last
  );

endinterface

//--- project.f
hw/img_geom_pkg.sv
hw/color_pkg.sv
hw/scan_if.sv
hw/frame_scanner.sv
hw/filter_selector.sv
hw/color_classifier.sv
hw/hist_accumulator.sv
hw/color_proc_top.sv
tb/tb_color_proc.sv

//--- tb/tb_color_proc.sv
// self-checking testbench, random frames from an LFSR, reference built from class_table
// memories are ideal, read data one cycle after the address, writes take effect at once
module tb_color_proc;
  import img_geom_pkg::*;
  import color_pkg::*;

  localparam int margin_cols = (img_cols - inframe_cols) / 2;
  localparam int margin_rows = (img_rows - inframe_rows) / 2;
  localparam int bin_cols = inframe_cols / hist_bins;
  localparam int frame_timeout = img_pxls + 64;

  logic clk;
  logic rst;
  logic proc_ctrl_i;
  logic new_frame_i;
  pxl_t orig_pxl_i;
  pxl_addr_t orig_addr_o;
  logic proc_we_o;
  pxl_t proc_pxl_o;
  pxl_addr_t proc_addr_o;
  logic new_frame_proc_o;
  pxl_count_t colorpxls_o;
  hist_bins_t hist_o;
  filter_mode_e filter_o;

  // memory models and expected results
  pxl_t orig_mem [img_pxls];
  pxl_t proc_mem [img_pxls];
  pxl_t exp_img [img_pxls];
  int exp_hist [hist_bins];
  int exp_total;

  logic [31:0] lfsr_state;
  pxl_addr_t rd_addr;
  pxl_addr_t exp_wr_addr;
  int wr_count;
  int done_count;
  logic prev_we;
  filter_mode_e cur_mode;

  color_proc_top color_proc_top_inst (
    .clk              (clk),
    .rst              (rst),
    .proc_ctrl_i      (proc_ctrl_i),
    .new_frame_i      (new_frame_i),
    .orig_pxl_i       (orig_pxl_i),
    .orig_addr_o      (orig_addr_o),
    .proc_we_o        (proc_we_o),
    .proc_pxl_o       (proc_pxl_o),
    .proc_addr_o      (proc_addr_o),
    .new_frame_proc_o (new_frame_proc_o),
    .colorpxls_o      (colorpxls_o),
    .hist_o           (hist_o),
    .filter_o         (filter_o)
  );

  always #5 clk = ~clk;

  // original image memory, address taken mid-cycle, data driven after the next edge
  always @(negedge clk) begin
    rd_addr <= orig_addr_o;
  end

  always @(posedge clk) begin
    #1;
    orig_pxl_i = orig_mem[rd_addr];
  end

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_pixel(string name, pxl_t got, pxl_t want);
    if (got !== want) begin
      $display("Fail t=%0t %s: got %h, expected %h", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic check_addr(string name, pxl_addr_t got, pxl_addr_t want);
    if (got !== want) begin
      $display("Fail t=%0t %s: got %0d, expected %0d", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic check_bin(string name, hist_val_t got, hist_val_t want);
    if (got !== want) begin
      $display("Fail t=%0t %s: got %0d, expected %0d", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic check_total(string name, pxl_count_t got, pxl_count_t want);
    if (got !== want) begin
      $display("Fail t=%0t %s: got %0d, expected %0d", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic check_mode(string name, filter_mode_e got, filter_mode_e want);
    if (got !== want) begin
      $display("Fail t=%0t %s: got %s, expected %s", $time, name, got.name(), want.name());
      stop_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic want);
    if (got !== want) begin
      $display("Fail t=%0t %s: got %b, expected %b", $time, name, got, want);
      stop_run();
    end
  endtask

  // write side monitor, checks the write order and the done pulse, keeps the written image
  always @(negedge clk) begin
    if (!rst) begin
      if (proc_we_o) begin
        check_addr("proc_addr_o", proc_addr_o, exp_wr_addr);
        proc_mem[proc_addr_o] = proc_pxl_o;
        exp_wr_addr = exp_wr_addr + 1'b1;
        wr_count++;
      end
      if (new_frame_proc_o) begin
        done_count++;
        if (!prev_we || proc_we_o) begin
          $display("done pulse at t=%0t is not on the cycle after the last write", $time);
          stop_run();
        end
      end
      prev_we = proc_we_o;
    end
  end

  // galois LFSR, shifts right, lsb is the output bit
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // class bits are red, green, blue, yellow, cyan, magenta, white from bit 0 up
  function automatic logic ref_pass(pxl_t p, filter_mode_e m);
    class_t c;
    c = class_table[{p[11:10], p[7:6], p[3:2]}];
    case (m)
      filt_red:     return c[0];
      filt_green:   return c[1];
      filt_blue:    return c[2];
      filt_yellow:  return c[3];
      filt_cyan:    return c[4];
      filt_magenta: return c[5];
      filt_white:   return c[6];
      default:      return 1'b1;
    endcase
  endfunction

  function automatic filter_mode_e next_mode(filter_mode_e m);
    case (m)
      filt_none:    return filt_red;
      filt_red:     return filt_green;
      filt_green:   return filt_blue;
      filt_blue:    return filt_yellow;
      filt_yellow:  return filt_magenta;
      filt_magenta: return filt_cyan;
      filt_cyan:    return filt_white;
      default:      return filt_none;
    endcase
  endfunction

  task automatic fill_image();
    logic [31:0] v;
    for (int a = 0; a < img_pxls; a++) begin
      take_bits(12, v);
      orig_mem[a] = pxl_t'(v[11:0]);
    end
  endtask

  // expected image, bins and total, counting only the inner frame
  task automatic build_reference(filter_mode_e mode);
    int col;
    int row;
    for (int b = 0; b < hist_bins; b++) begin
      exp_hist[b] = 0;
    end
    exp_total = 0;
    for (int a = 0; a < img_pxls; a++) begin
      col = a % img_cols;
      row = a / img_cols;
      if (ref_pass(orig_mem[a], mode)) begin
        exp_img[a] = orig_mem[a];
        if (col >= margin_cols && col < img_cols - margin_cols &&
            row >= margin_rows && row < img_rows - margin_rows) begin
          exp_hist[(col - margin_cols) / bin_cols]++;
          exp_total++;
        end
      end else begin
        exp_img[a] = '0;
      end
    end
  endtask

  // all driving and checking happens just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic press_button(filter_mode_e want);
    int n;
    proc_ctrl_i = 1'b1;
    n = 0;
    while (filter_o !== want && n < 8) begin
      next_cycle();
      n++;
    end
    if (filter_o !== want) begin
      $display("filter_o did not reach %s within 8 cycles of a press", want.name());
      stop_run();
    end
    proc_ctrl_i = 1'b0;
    // let the release pass the synchronizer, mode must not step again
    repeat (6) next_cycle();
    check_mode("filter_o", filter_o, want);
  endtask

  task automatic step_to(filter_mode_e target);
    while (cur_mode != target) begin
      cur_mode = next_mode(cur_mode);
      press_button(cur_mode);
    end
  endtask

  task automatic run_frame(filter_mode_e mode, bit pulse_twice);
    int n;
    pxl_count_t bin_sum;
    fill_image();
    build_reference(mode);
    wr_count = 0;
    done_count = 0;
    exp_wr_addr = '0;
    new_frame_i = 1'b1;
    next_cycle();
    new_frame_i = 1'b0;
    if (pulse_twice) begin
      // request in the middle of the frame
      repeat (200) next_cycle();
      new_frame_i = 1'b1;
      next_cycle();
      new_frame_i = 1'b0;
    end
    n = 0;
    while (done_count == 0 && n < frame_timeout) begin
      next_cycle();
      n++;
    end
    if (done_count == 0) begin
      $display("timeout waiting for new_frame_proc_o in mode %s", mode.name());
      stop_run();
    end
    // a frame started by mistake would write again in this window
    repeat (32) next_cycle();
    if (done_count != 1 || wr_count != img_pxls) begin
      $display("mode %s: expected 1 done pulse and %0d writes, saw %0d and %0d",
               mode.name(), img_pxls, done_count, wr_count);
      stop_run();
    end
    bin_sum = '0;
    for (int b = 0; b < hist_bins; b++) begin
      check_bin($sformatf("hist_o[%0d]", b), hist_o[b], hist_val_t'(exp_hist[b]));
      bin_sum = bin_sum + pxl_count_t'(hist_o[b]);
    end
    check_total("colorpxls_o", colorpxls_o, pxl_count_t'(exp_total));
    check_total("sum of hist_o", bin_sum, colorpxls_o);
    // written image against the reference image
    for (int a = 0; a < img_pxls; a++) begin
      check_pixel($sformatf("stored pixel %0d", a), proc_mem[a], exp_img[a]);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    proc_ctrl_i = 1'b0;
    new_frame_i = 1'b0;
    orig_pxl_i = '0;
    rd_addr = '0;
    exp_wr_addr = '0;
    wr_count = 0;
    done_count = 0;
    prev_we = 1'b0;
    cur_mode = filt_none;
    lfsr_state = 32'hd93a;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle();

    // state right after reset
    check_mode("filter_o", filter_o, filt_none);
    check_flag("proc_we_o", proc_we_o, 1'b0);
    check_flag("new_frame_proc_o", new_frame_proc_o, 1'b0);
    check_addr("orig_addr_o", orig_addr_o, '0);
    check_total("colorpxls_o", colorpxls_o, '0);
    for (int b = 0; b < hist_bins; b++) begin
      check_bin($sformatf("hist_o[%0d]", b), hist_o[b], '0);
    end

    // no filtering, every inner pixel counts
    run_frame(filt_none, 1'b0);

    // one full lap through the modes
    for (int i = 0; i < 8; i++) begin
      cur_mode = next_mode(cur_mode);
      press_button(cur_mode);
    end
    check_mode("filter_o", filter_o, filt_none);

    step_to(filt_red);
    run_frame(cur_mode, 1'b0);
    step_to(filt_cyan);
    run_frame(cur_mode, 1'b0);
    step_to(filt_white);
    run_frame(cur_mode, 1'b0);

    // second start request while busy
    step_to(filt_none);
    run_frame(cur_mode, 1'b1);

    $display("Regression passed");
    $finish;
  end

endmodule
